//--- src.f
+incdir+dv
source/issue_pkg.sv
source/decoded_if.sv
source/issue_controller.sv
source/decode_stage.sv
source/pair_check_stage.sv
source/issue_top.sv
dv/issue_tb.sv

//--- run.sh
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --timescale 1ns/1ps \
    --top-module issue_tb -f src.f -o issue_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

//--- dv/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

typedef struct packed {
    logic     regwrite;
    reg_idx_t dest;
    logic     memreq, isbranch, isjump;
    logic     needrs, needrt;
    reg_idx_t rs, rt;
    logic     needhi, needlo, hiwrite, lowrite, cp0rel;
} slot_t;

typedef struct packed {
    logic     valid, dual;
    logic     s0_regwrite;
    reg_idx_t s0_dest;
    logic     s0_memreq, s0_isbranch, s0_isjump;
    logic     s1_regwrite;
    reg_idx_t s1_dest;
    logic     s1_memreq, s1_isbranch, s1_isjump;
} result_t;

function automatic slot_t decode_word(input inst_t w);
    slot_t      s;
    logic [5:0] op;
    logic [5:0] fn;
    logic [1:0] wsel;  // 0 none, 1 rt, 2 rd, 3 r31
    logic       alu3, shift, muldv, load, store, imm, eret, mfc0, mtc0;
    op    = w[31:26];
    fn    = w[5:0];
    s     = '0;
    wsel  = 2'd0;
    s.rs  = w[25:21];
    s.rt  = w[20:16];
    eret  = (op == 6'h10) && (fn == 6'h18);
    mfc0  = (op == 6'h10) && !eret && (w[25:21] == 5'd0);
    mtc0  = (op == 6'h10) && !eret && (w[25:21] == 5'd4);
    s.cp0rel = eret || mfc0 || mtc0;
    if (op == 6'h00)
    begin
        alu3  = fn inside {[6'h20:6'h27], 6'h2a, 6'h2b, 6'h04, 6'h06, 6'h07};
        shift = fn inside {6'h00, 6'h02, 6'h03};
        muldv = (fn[5:2] == 4'b0110);  // MULT MULTU DIV DIVU
        s.needrs  = alu3 || muldv || fn inside {6'h08, 6'h09, 6'h11, 6'h13};
        s.needrt  = alu3 || muldv || shift;
        s.isjump  = fn inside {6'h08, 6'h09};
        s.needhi  = (fn == 6'h10);
        s.needlo  = (fn == 6'h12);
        s.hiwrite = muldv || (fn == 6'h11);
        s.lowrite = muldv || (fn == 6'h13);
        if (alu3 || shift || fn inside {6'h09, 6'h10, 6'h12})
            wsel = 2'd2;
    end
    else
    begin
        load  = op inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
        store = op inside {6'h28, 6'h29, 6'h2b};
        imm   = op inside {[6'h08:6'h0e]};
        s.memreq   = load || store;
        s.isbranch = op inside {6'h01, [6'h04:6'h07]};
        s.isjump   = op inside {6'h02, 6'h03};
        s.needrs   = load || store || imm || s.isbranch;
        s.needrt   = store || mtc0 || op inside {6'h04, 6'h05};
        if (load || imm || mfc0 || op == 6'h0f)
            wsel = 2'd1;
        if (op == 6'h03 || (op == 6'h01 && w[20:17] != 4'd0))  // JAL and linking REGIMM
            wsel = 2'd3;
    end
    s.regwrite = (wsel != 2'd0);
    case (wsel)
        2'd1:    s.dest = w[20:16];
        2'd2:    s.dest = w[15:11];
        2'd3:    s.dest = 5'd31;
        default: s.dest = 5'd0;
    endcase
    return s;
endfunction

function automatic logic dual_allowed(input slot_t a, input slot_t b, input int mem_ports);
    logic raw, hilo, mem, ctrl, cp0;
    raw  = a.regwrite && (a.dest != 5'd0)
           && ((b.needrs && b.rs == a.dest) || (b.needrt && b.rt == a.dest));
    hilo = (a.hiwrite && b.needhi) || (a.lowrite && b.needlo);
    mem  = (mem_ports == 1) && a.memreq && b.memreq;
    ctrl = b.isbranch || b.isjump;
    cp0  = a.cp0rel || b.cp0rel;
    return !(raw || hilo || mem || ctrl || cp0);
endfunction

function automatic result_t predict_pair(input logic valid, input inst_t w0, input inst_t w1,
                                         input int mem_ports);
    result_t p;
    slot_t   a;
    slot_t   b;
    a = decode_word(w0);
    b = decode_word(w1);
    p = '0;
    if (valid)
    begin
        p.valid       = 1'b1;
        p.dual        = dual_allowed(a, b, mem_ports);
        p.s0_regwrite = a.regwrite;
        p.s0_dest     = a.dest;
        p.s0_memreq   = a.memreq;
        p.s0_isbranch = a.isbranch;
        p.s0_isjump   = a.isjump;
        if (p.dual)  // Slot 1 shows only on a dual issue
        begin
            p.s1_regwrite = b.regwrite;
            p.s1_dest     = b.dest;
            p.s1_memreq   = b.memreq;
            p.s1_isbranch = b.isbranch;
            p.s1_isjump   = b.isjump;
        end
    end
    return p;
endfunction

`endif

//--- dv/issue_tb.sv
module issue_tb
    import issue_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "issue_model.svh"

    localparam int MEM_PORTS     = 1;
    localparam int RESET_CYCLES  = 10;
    localparam int RESET_TIMEOUT = 50;

    localparam logic [26*6-1:0] SPECIAL_FUNCTS = {
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
        6'h04, 6'h06, 6'h07, 6'h00, 6'h02, 6'h03, 6'h08, 6'h09,
        6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b
    };
    localparam logic [24*6-1:0] OTHER_OPS = {
        6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
        6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b, 6'h10
    };

    logic     clk, rst_n, in_valid;
    inst_t    inst0, inst1;
    logic     issue_valid, issue_dual;
    logic     s0_regwrite, s0_memreq, s0_isbranch, s0_isjump;
    logic     s1_regwrite, s1_memreq, s1_isbranch, s1_isjump;
    reg_idx_t s0_dest, s1_dest;

    integer   seed;
    result_t  pipe [$];  // Expected results of the two pairs in flight
    string    test_name;
    int       checks, errors, test_errors, tests_run, tests_failed;
    logic     timed_out;

    issue_top #(
        .MEM_PORTS (MEM_PORTS)
    ) i_issue_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .inst0       (inst0),
        .inst1       (inst1),
        .issue_valid (issue_valid),
        .issue_dual  (issue_dual),
        .s0_regwrite (s0_regwrite),
        .s0_dest     (s0_dest),
        .s0_memreq   (s0_memreq),
        .s0_isbranch (s0_isbranch),
        .s0_isjump   (s0_isjump),
        .s1_regwrite (s1_regwrite),
        .s1_dest     (s1_dest),
        .s1_memreq   (s1_memreq),
        .s1_isbranch (s1_isbranch),
        .s1_isjump   (s1_isjump)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            test_errors++;
            $display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs(input result_t e);
        check_value("issue_valid", 32'(e.valid), 32'(issue_valid));
        check_value("issue_dual", 32'(e.dual), 32'(issue_dual));
        check_value("s0_regwrite", 32'(e.s0_regwrite), 32'(s0_regwrite));
        check_value("s0_dest", 32'(e.s0_dest), 32'(s0_dest));
        check_value("s0_memreq", 32'(e.s0_memreq), 32'(s0_memreq));
        check_value("s0_isbranch", 32'(e.s0_isbranch), 32'(s0_isbranch));
        check_value("s0_isjump", 32'(e.s0_isjump), 32'(s0_isjump));
        check_value("s1_regwrite", 32'(e.s1_regwrite), 32'(s1_regwrite));
        check_value("s1_dest", 32'(e.s1_dest), 32'(s1_dest));
        check_value("s1_memreq", 32'(e.s1_memreq), 32'(s1_memreq));
        check_value("s1_isbranch", 32'(e.s1_isbranch), 32'(s1_isbranch));
        check_value("s1_isjump", 32'(e.s1_isjump), 32'(s1_isjump));
    endtask

    // Output after this edge belongs to the pair driven two edges back
    task drive_pair(input logic valid, input inst_t w0, input inst_t w1);
        @(posedge clk);
        #1;
        compare_outputs(pipe.pop_front());
        in_valid = valid;
        inst0    = w0;
        inst1    = w1;
        pipe.push_back(predict_pair(valid, w0, w1, MEM_PORTS));
    endtask

    task directed_pair(input inst_t w0, input inst_t w1, input logic want_dual);
        result_t p;
        p = predict_pair(1'b1, w0, w1, MEM_PORTS);
        check_value("model dual", 32'(want_dual), 32'(p.dual));
        drive_pair(1'b1, w0, w1);
    endtask

    function automatic inst_t r_type(input logic [5:0] fn, input reg_idx_t rs,
                                     input reg_idx_t rt, input reg_idx_t rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic inst_t i_type(input logic [5:0] op, input reg_idx_t rs,
                                     input reg_idx_t rt);
        return {op, rs, rt, 16'h0040};
    endfunction

    task random_inst(output inst_t w);
        logic [31:0] r;
        logic [31:0] k;
        int          idx;
        r   = $random(seed);
        k   = $random(seed);
        idx = int'(k[5:0]);
        w   = r;  // Junk in the other fields
        if (idx < 26)
        begin
            w[31:26] = 6'h00;
            w[5:0]   = SPECIAL_FUNCTS[idx*6 +: 6];
        end
        else if (idx < 50)
            w[31:26] = OTHER_OPS[(idx-26)*6 +: 6];
        if (w[31:26] == 6'h10)  // Mostly real MFC0 MTC0 ERET
        begin
            case (k[9:8])
                2'd0:    w[25:21] = 5'd0;
                2'd1:    w[25:21] = 5'd4;
                2'd2:    w[5:0] = 6'h18;
                default: w[5:0] = r[5:0];
            endcase
        end
        if (w[31:26] == 6'h01 && k[10])
            w[20:16] = {4'd0, k[11]};  // BLTZ or BGEZ
    endtask

    task random_pair(output inst_t w0, output inst_t w1);
        slot_t       a;
        logic [31:0] k;
        random_inst(w0);
        random_inst(w1);
        a = decode_word(w0);
        k = $random(seed);
        if (k[1:0] == 2'd0)
            w1[25:21] = a.dest;  // Provoke a dependence
        else if (k[1:0] == 2'd1)
            w1[20:16] = a.dest;
    endtask

    task begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task end_test();
        drive_pair(1'b0, '0, '0);  // Flush both pairs still in flight
        drive_pair(1'b0, '0, '0);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %s done, %0d errors", test_name, test_errors);
    endtask

    task wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1)
        begin
            timed_out = 1'b1;
            $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task random_test(input string name, input int count, input logic all_valid);
        inst_t       w0;
        inst_t       w1;
        logic [31:0] k;
        begin_test(name);
        for (int i = 0; i < count; i++)
        begin
            random_pair(w0, w1);
            k = $random(seed);
            drive_pair(all_valid || k[1:0] != 2'd0, w0, w1);
        end
        end_test();
    endtask

    task idle_test();
        inst_t w0;
        inst_t w1;
        begin_test("idle_drop");
        for (int i = 0; i < 6; i++)
        begin
            random_pair(w0, w1);
            drive_pair(1'b0, w0, w1);  // Dropped, outputs stay 0
        end
        end_test();
    endtask

    task raw_test();
        begin_test("raw_hazard");
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), r_type(6'h20, 5'd5, 5'd3, 5'd6), 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), r_type(6'h22, 5'd3, 5'd5, 5'd6), 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd0), r_type(6'h20, 5'd0, 5'd0, 5'd6), 1'b1);
        directed_pair(i_type(6'h08, 5'd1, 5'd7), i_type(6'h2b, 5'd2, 5'd7), 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), r_type(6'h00, 5'd5, 5'd3, 5'd6), 1'b1);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), i_type(6'h0f, 5'd5, 5'd8), 1'b1);
        directed_pair(i_type(6'h08, 5'd1, 5'd7), i_type(6'h0d, 5'd7, 5'd9), 1'b0);
        end_test();
    endtask

    task hilo_mem_cp0_test();
        begin_test("hilo_mem_cp0");
        directed_pair(r_type(6'h18, 5'd1, 5'd2, 5'd0), r_type(6'h10, 5'd0, 5'd0, 5'd3), 1'b0);
        directed_pair(r_type(6'h11, 5'd1, 5'd0, 5'd0), r_type(6'h10, 5'd0, 5'd0, 5'd4), 1'b0);
        directed_pair(r_type(6'h13, 5'd1, 5'd0, 5'd0), r_type(6'h12, 5'd0, 5'd0, 5'd4), 1'b0);
        directed_pair(r_type(6'h11, 5'd1, 5'd0, 5'd0), r_type(6'h12, 5'd0, 5'd0, 5'd4), 1'b1);
        directed_pair(i_type(6'h23, 5'd1, 5'd8), i_type(6'h23, 5'd2, 5'd9), 1'b0);
        directed_pair(i_type(6'h23, 5'd1, 5'd8), i_type(6'h2b, 5'd2, 5'd3), 1'b0);
        directed_pair(i_type(6'h2b, 5'd1, 5'd8), r_type(6'h20, 5'd2, 5'd3, 5'd4), 1'b1);
        directed_pair({6'h10, 1'b1, 19'd0, 6'h18}, r_type(6'h20, 5'd2, 5'd3, 5'd4), 1'b0);
        directed_pair(r_type(6'h20, 5'd2, 5'd3, 5'd4), {6'h10, 5'd0, 5'd9, 5'd12, 11'd0}, 1'b0);
        directed_pair({6'h10, 5'd4, 5'd9, 5'd12, 11'd0}, r_type(6'h20, 5'd2, 5'd3, 5'd4), 1'b0);
        end_test();
    endtask

    task branch_test();
        begin_test("branch_slot");
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), i_type(6'h04, 5'd1, 5'd2), 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), {6'h02, 26'h100}, 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), r_type(6'h08, 5'd9, 5'd0, 5'd0), 1'b0);
        directed_pair(r_type(6'h20, 5'd1, 5'd2, 5'd5), i_type(6'h01, 5'd3, 5'h11), 1'b0);
        directed_pair(i_type(6'h04, 5'd1, 5'd2), r_type(6'h20, 5'd3, 5'd4, 5'd6), 1'b1);
        directed_pair({6'h02, 26'h100}, r_type(6'h20, 5'd3, 5'd4, 5'd6), 1'b1);
        directed_pair({6'h03, 26'h100}, r_type(6'h20, 5'd3, 5'd4, 5'd6), 1'b1);
        directed_pair(i_type(6'h01, 5'd3, 5'h10), r_type(6'h20, 5'd31, 5'd4, 5'd6), 1'b0);
        end_test();
    endtask

    initial
    begin
        in_valid     = 1'b0;
        inst0        = '0;
        inst1        = '0;
        seed         = 32'h8d18;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        test_name    = "reset";
        wait_reset_release();
        if (!timed_out)
        begin
            pipe.push_back(predict_pair(1'b0, '0, '0, MEM_PORTS));
            pipe.push_back(predict_pair(1'b0, '0, '0, MEM_PORTS));
            idle_test();
            random_test("random_decode", 300, 1'b0);
            raw_test();
            hilo_mem_cp0_test();
            branch_test();
            random_test("back_to_back", 200, 1'b1);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/issue_top.sv
module issue_top
    import issue_pkg::*;
#(
    parameter int MEM_PORTS = 1
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  inst_t    inst0,
    input  inst_t    inst1,

    output logic     issue_valid,
    output logic     issue_dual,
    output logic     s0_regwrite,
    output reg_idx_t s0_dest,
    output logic     s0_memreq,
    output logic     s0_isbranch,
    output logic     s0_isjump,
    output logic     s1_regwrite,
    output reg_idx_t s1_dest,
    output logic     s1_memreq,
    output logic     s1_isbranch,
    output logic     s1_isjump
);

    decoded_if i_decoded_if ();

    decode_stage i_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .inst0    (inst0),
        .inst1    (inst1),
        .dec      (i_decoded_if.stage)
    );

    pair_check_stage #(
        .MEM_PORTS (MEM_PORTS)
    ) i_pair_check_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (i_decoded_if.check),
        .issue_valid (issue_valid),
        .issue_dual  (issue_dual),
        .s0_regwrite (s0_regwrite),
        .s0_dest     (s0_dest),
        .s0_memreq   (s0_memreq),
        .s0_isbranch (s0_isbranch),
        .s0_isjump   (s0_isjump),
        .s1_regwrite (s1_regwrite),
        .s1_dest     (s1_dest),
        .s1_memreq   (s1_memreq),
        .s1_isbranch (s1_isbranch),
        .s1_isjump   (s1_isjump)
    );

endmodule

//--- source/pair_check_stage.sv
module pair_check_stage
    import issue_pkg::*;
#(
    parameter int MEM_PORTS = 1
)
(
    input  logic     clk,
    input  logic     rst_n,
    decoded_if.check dec,

    output logic     issue_valid,
    output logic     issue_dual,
    output logic     s0_regwrite,
    output reg_idx_t s0_dest,
    output logic     s0_memreq,
    output logic     s0_isbranch,
    output logic     s0_isjump,
    output logic     s1_regwrite,
    output reg_idx_t s1_dest,
    output logic     s1_memreq,
    output logic     s1_isbranch,
    output logic     s1_isjump
);

    logic raw_hazard;
    logic hilo_hazard;
    logic mem_hazard;
    logic ctrl_hazard;
    logic cp0_hazard;
    logic dual_d;

    assign raw_hazard  = dec.s0_regwrite && (dec.s0_dest != '0)
                         && ((dec.s1_needrs && dec.s1_rs == dec.s0_dest)
                             || (dec.s1_needrt && dec.s1_rt == dec.s0_dest));
    assign hilo_hazard = (dec.s0_hiwrite && dec.s1_needhi)
                         || (dec.s0_lowrite && dec.s1_needlo);
    assign mem_hazard  = (MEM_PORTS == 1) && dec.s0_memreq && dec.s1_memreq;
    assign ctrl_hazard = dec.s1_isbranch || dec.s1_isjump;  // Slot 1 may not redirect
    assign cp0_hazard  = dec.s0_cp0rel || dec.s1_cp0rel;

    assign dual_d = dec.pair_valid
                    && !(raw_hazard || hilo_hazard || mem_hazard || ctrl_hazard || cp0_hazard);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            issue_valid <= 1'b0;
            issue_dual  <= 1'b0;
            s0_regwrite <= 1'b0;
            s0_dest     <= '0;
            s0_memreq   <= 1'b0;
            s0_isbranch <= 1'b0;
            s0_isjump   <= 1'b0;
            s1_regwrite <= 1'b0;
            s1_dest     <= '0;
            s1_memreq   <= 1'b0;
            s1_isbranch <= 1'b0;
            s1_isjump   <= 1'b0;
        end
        else
        begin
            issue_valid <= dec.pair_valid;
            issue_dual  <= dual_d;
            s0_regwrite <= dec.pair_valid && dec.s0_regwrite;
            s0_dest     <= dec.pair_valid ? dec.s0_dest : '0;
            s0_memreq   <= dec.pair_valid && dec.s0_memreq;
            s0_isbranch <= dec.pair_valid && dec.s0_isbranch;
            s0_isjump   <= dec.pair_valid && dec.s0_isjump;
            s1_regwrite <= dual_d && dec.s1_regwrite;  // Slot 1 only when dual
            s1_dest     <= dual_d ? dec.s1_dest : '0;
            s1_memreq   <= dual_d && dec.s1_memreq;
            s1_isbranch <= dual_d && dec.s1_isbranch;
            s1_isjump   <= dual_d && dec.s1_isjump;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        issue_dual |-> issue_valid);

    assert property (@(posedge clk) disable iff (!rst_n)
        (MEM_PORTS == 1) && issue_dual |-> !(s0_memreq && s1_memreq));

endmodule

//--- source/decode_stage.sv
module decode_stage
    import issue_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  inst_t    inst0,
    input  inst_t    inst1,
    decoded_if.stage dec
);

    inst_t    inst [2];
    opcode_t  op [2];
    funct_t   funct [2];
    rfunct_t  rfunct [2];
    c0funct_t c0funct [2];
    reg_idx_t rs [2], rt [2], rd [2], dest [2];
    regdst_e  regdst [2];
    logic     regwrite [2], memreq [2], isbranch [2], isjump [2], cp0rel [2];
    logic     needrs [2], needrt [2], needhi [2], needlo [2], hiwrite [2], lowrite [2];

    assign inst[0] = inst0;
    assign inst[1] = inst1;

    for (genvar i = 0; i < 2; i++)
    begin : g_slot
        assign op[i]      = inst[i][31:26];
        assign rs[i]      = inst[i][25:21];
        assign rt[i]      = inst[i][20:16];
        assign rd[i]      = inst[i][15:11];
        assign funct[i]   = inst[i][5:0];
        assign rfunct[i]  = inst[i][20:16];
        assign c0funct[i] = inst[i][25:21];

        issue_controller i_issue_controller (
            .d_op          (op[i]),
            .d_funct       (funct[i]),
            .d_branchfunct (rfunct[i]),
            .d_c0funct     (c0funct[i]),
            .d_memreq      (memreq[i]),
            .d_regwrite    (regwrite[i]),
            .d_regdst      (regdst[i]),
            .d_hiwrite     (hiwrite[i]),
            .d_lowrite     (lowrite[i]),
            .d_isbranch    (isbranch[i]),
            .d_isjump      (isjump[i]),
            .d_needrs      (needrs[i]),
            .d_needrt      (needrt[i]),
            .d_needhi      (needhi[i]),
            .d_needlo      (needlo[i]),
            .d_cp0rel      (cp0rel[i])
        );

        // No write means no destination
        assign dest[i] = !regwrite[i]          ? '0 :
                         (regdst[i] == DST_RD)  ? rd[i] :
                         (regdst[i] == DST_R31) ? reg_idx_t'(31) : rt[i];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            dec.pair_valid <= 1'b0;
        else
            dec.pair_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            dec.s0_regwrite <= regwrite[0];
            dec.s0_dest     <= dest[0];
            dec.s0_memreq   <= memreq[0];
            dec.s0_isbranch <= isbranch[0];
            dec.s0_isjump   <= isjump[0];
            dec.s0_needrs   <= needrs[0];
            dec.s0_needrt   <= needrt[0];
            dec.s0_rs       <= rs[0];
            dec.s0_rt       <= rt[0];
            dec.s0_needhi   <= needhi[0];
            dec.s0_needlo   <= needlo[0];
            dec.s0_hiwrite  <= hiwrite[0];
            dec.s0_lowrite  <= lowrite[0];
            dec.s0_cp0rel   <= cp0rel[0];
            dec.s1_regwrite <= regwrite[1];
            dec.s1_dest     <= dest[1];
            dec.s1_memreq   <= memreq[1];
            dec.s1_isbranch <= isbranch[1];
            dec.s1_isjump   <= isjump[1];
            dec.s1_needrs   <= needrs[1];
            dec.s1_needrt   <= needrt[1];
            dec.s1_rs       <= rs[1];
            dec.s1_rt       <= rt[1];
            dec.s1_needhi   <= needhi[1];
            dec.s1_needlo   <= needlo[1];
            dec.s1_hiwrite  <= hiwrite[1];
            dec.s1_lowrite  <= lowrite[1];
            dec.s1_cp0rel   <= cp0rel[1];
        end
    end

    // An accepted pair never reports a destination for a non-writing slot
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> (dec.s0_regwrite || dec.s0_dest == '0)
                     && (dec.s1_regwrite || dec.s1_dest == '0));

endmodule

//--- source/issue_controller.sv
module issue_controller
    import issue_pkg::*;
(
    input  opcode_t  d_op,
    input  funct_t   d_funct,
    input  rfunct_t  d_branchfunct,
    input  c0funct_t d_c0funct,

    output logic     d_memreq,
    output logic     d_regwrite,
    output regdst_e  d_regdst,
    output logic     d_hiwrite,
    output logic     d_lowrite,
    output logic     d_isbranch,
    output logic     d_isjump,
    output logic     d_needrs,
    output logic     d_needrt,
    output logic     d_needhi,
    output logic     d_needlo,
    output logic     d_cp0rel
);

    logic is_special;
    logic is_cop0;

    assign is_special = (d_op == OP_SPECIAL);
    assign is_cop0    = (d_op == OP_COP0);

    always_comb
    begin
        d_regwrite = 1'b0;
        d_regdst   = DST_RT;
        d_needrs   = 1'b0;
        d_needrt   = 1'b0;
        case (d_op)
            OP_SPECIAL:
            begin
                case (d_funct)
                    6'b100000, 6'b100001, 6'b100010, 6'b100011,  // ADD ADDU SUB SUBU
                    6'b100100, 6'b100101, 6'b100110, 6'b100111,  // AND OR XOR NOR
                    6'b101010, 6'b101011,                        // SLT SLTU
                    6'b000100, 6'b000110, 6'b000111:             // SLLV SRLV SRAV
                    begin
                        d_regwrite = 1'b1;
                        d_regdst   = DST_RD;
                        d_needrs   = 1'b1;
                        d_needrt   = 1'b1;
                    end
                    6'b000000, 6'b000010, 6'b000011:             // SLL SRL SRA
                    begin
                        d_regwrite = 1'b1;
                        d_regdst   = DST_RD;
                        d_needrt   = 1'b1;
                    end
                    F_JALR:
                    begin
                        d_regwrite = 1'b1;
                        d_regdst   = DST_RD;
                        d_needrs   = 1'b1;
                    end
                    F_MFHI, F_MFLO:
                    begin
                        d_regwrite = 1'b1;
                        d_regdst   = DST_RD;
                    end
                    F_JR, F_MTHI, F_MTLO:
                    begin
                        d_needrs = 1'b1;
                    end
                    F_MULT, F_MULTU, F_DIV, F_DIVU:
                    begin
                        d_needrs = 1'b1;
                        d_needrt = 1'b1;
                    end
                    default: d_regwrite = 1'b0;  // BREAK SYSCALL and junk
                endcase
            end
            OP_REGIMM:
            begin
                d_needrs = 1'b1;
                // Only BLTZ and BGEZ skip the link, unknown variants link too
                if (d_branchfunct != 5'b00000 && d_branchfunct != 5'b00001)
                begin
                    d_regwrite = 1'b1;
                    d_regdst   = DST_R31;
                end
            end
            6'b000100, 6'b000101:                                // BEQ BNE
            begin
                d_needrs = 1'b1;
                d_needrt = 1'b1;
            end
            6'b000110, 6'b000111:                                // BLEZ BGTZ
            begin
                d_needrs = 1'b1;
            end
            OP_JAL:
            begin
                d_regwrite = 1'b1;
                d_regdst   = DST_R31;
            end
            6'b001000, 6'b001001, 6'b001010, 6'b001011,          // ADDI ADDIU SLTI SLTIU
            6'b001100, 6'b001101, 6'b001110,                     // ANDI ORI XORI
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                d_regwrite = 1'b1;
                d_needrs   = 1'b1;
            end
            6'b001111:                                           // LUI
            begin
                d_regwrite = 1'b1;
            end
            OP_SB, OP_SH, OP_SW:
            begin
                d_needrs = 1'b1;
                d_needrt = 1'b1;
            end
            OP_COP0:
            begin
                if (d_funct == F_ERET)
                begin
                    d_regwrite = 1'b0;
                end
                else if (d_c0funct == C0_MF)
                begin
                    d_regwrite = 1'b1;
                end
                else if (d_c0funct == C0_MT)
                begin
                    d_needrt = 1'b1;
                end
            end
            default: d_regwrite = 1'b0;  // J and unknown opcodes
        endcase
    end

    assign d_isbranch = d_op inside {6'b000100, 6'b000101, OP_REGIMM, 6'b000110, 6'b000111};
    assign d_isjump   = (is_special && d_funct inside {F_JR, F_JALR})
                        || d_op inside {OP_J, OP_JAL};
    assign d_memreq   = d_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

    assign d_cp0rel = is_cop0
                      && (d_funct == F_ERET || d_c0funct == C0_MF || d_c0funct == C0_MT);

    assign d_needhi  = is_special && (d_funct == F_MFHI);
    assign d_needlo  = is_special && (d_funct == F_MFLO);
    assign d_hiwrite = is_special && d_funct inside {F_MTHI, F_MULT, F_MULTU, F_DIV, F_DIVU};
    assign d_lowrite = is_special && d_funct inside {F_MTLO, F_MULT, F_MULTU, F_DIV, F_DIVU};

endmodule

//--- source/decoded_if.sv
interface decoded_if
    import issue_pkg::*;
();

    logic     pair_valid;

    logic     s0_regwrite, s0_memreq, s0_isbranch, s0_isjump, s0_cp0rel;
    logic     s0_needrs, s0_needrt, s0_needhi, s0_needlo, s0_hiwrite, s0_lowrite;
    reg_idx_t s0_dest, s0_rs, s0_rt;

    logic     s1_regwrite, s1_memreq, s1_isbranch, s1_isjump, s1_cp0rel;
    logic     s1_needrs, s1_needrt, s1_needhi, s1_needlo, s1_hiwrite, s1_lowrite;
    reg_idx_t s1_dest, s1_rs, s1_rt;

    modport stage (
        output pair_valid,
        output s0_regwrite, s0_memreq, s0_isbranch, s0_isjump, s0_cp0rel,
        output s0_needrs, s0_needrt, s0_needhi, s0_needlo, s0_hiwrite, s0_lowrite,
        output s0_dest, s0_rs, s0_rt,
        output s1_regwrite, s1_memreq, s1_isbranch, s1_isjump, s1_cp0rel,
        output s1_needrs, s1_needrt, s1_needhi, s1_needlo, s1_hiwrite, s1_lowrite,
        output s1_dest, s1_rs, s1_rt
    );

    modport check (
        input pair_valid,
        input s0_regwrite, s0_memreq, s0_isbranch, s0_isjump, s0_cp0rel,
        input s0_needrs, s0_needrt, s0_needhi, s0_needlo, s0_hiwrite, s0_lowrite,
        input s0_dest, s0_rs, s0_rt,
        input s1_regwrite, s1_memreq, s1_isbranch, s1_isjump, s1_cp0rel,
        input s1_needrs, s1_needrt, s1_needhi, s1_needlo, s1_hiwrite, s1_lowrite,
        input s1_dest, s1_rs, s1_rt
    );

endinterface

//--- source/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  rfunct_t;   // REGIMM variant in bits 20..16
    typedef logic [4:0]  c0funct_t;  // COP0 sub-op in bits 25..21
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        DST_RT  = 2'b00,
        DST_RD  = 2'b01,
        DST_R31 = 2'b10
    } regdst_e;

    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_COP0    = 6'b010000;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    localparam funct_t F_JR    = 6'b001000;
    localparam funct_t F_JALR  = 6'b001001;
    localparam funct_t F_MFHI  = 6'b010000;
    localparam funct_t F_MTHI  = 6'b010001;
    localparam funct_t F_MFLO  = 6'b010010;
    localparam funct_t F_MTLO  = 6'b010011;
    localparam funct_t F_MULT  = 6'b011000;
    localparam funct_t F_MULTU = 6'b011001;
    localparam funct_t F_DIV   = 6'b011010;
    localparam funct_t F_DIVU  = 6'b011011;
    localparam funct_t F_ERET  = 6'b011000;  // Under OP_COP0

    localparam c0funct_t C0_MF = 5'b00000;
    localparam c0funct_t C0_MT = 5'b00100;

endpackage
